// File: hw/mipsPkg.sv
`default_nettype none

package mipsPkg;

	localparam int DataWidth = 32;
	localparam int RegAddrBits = 5;

	typedef enum logic [5:0] {
		OpRtype = 6'h00,
		OpBeq   = 6'h04,
		OpBne   = 6'h05,
		OpAddi  = 6'h08,
		OpAndi  = 6'h0c,
		OpOri   = 6'h0d,
		OpLw    = 6'h23,
		OpSw    = 6'h2b,
		OpHalt  = 6'h3f
	} opcode_e;

	typedef enum logic [5:0] {
		FuncAdd = 6'h20,
		FuncSub = 6'h22,
		FuncAnd = 6'h24,
		FuncOr  = 6'h25,
		FuncSlt = 6'h2a
	} func_e;

	typedef enum logic [2:0] {
		AluAdd,
		AluSub,
		AluAnd,
		AluOr,
		AluSlt
	} aluOp_e;

	typedef struct packed {
		opcode_e op;
		logic [RegAddrBits-1:0] rs;
		logic [RegAddrBits-1:0] rt;
		logic [RegAddrBits-1:0] rd;
		logic [4:0] sa;
		func_e func;
	} rType_t;

	typedef struct packed {
		opcode_e op;
		logic [RegAddrBits-1:0] rs;
		logic [RegAddrBits-1:0] rt;
		logic [15:0] imm16;
	} iType_t;

	// Same instruction word seen through either field layout
	typedef union packed {
		rType_t r;
		iType_t i;
	} instr_u;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memWrite;
		logic aluSrc;
		logic regDst;
		logic zeroExt;
		logic branch;
		logic branchNe;
		logic halt;
		aluOp_e aluOp;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [DataWidth-1:0] rsData;
		logic [DataWidth-1:0] rtData;
		logic [DataWidth-1:0] imm;
		logic [RegAddrBits-1:0] rs;
		logic [RegAddrBits-1:0] rt;
		logic [RegAddrBits-1:0] rd;
	} idEx_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [DataWidth-1:0] aluResult;
		logic [DataWidth-1:0] storeData;
		logic [RegAddrBits-1:0] dest;
	} exMem_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [DataWidth-1:0] aluResult;
		logic [DataWidth-1:0] loadData;
		logic [RegAddrBits-1:0] dest;
	} memWb_t;

	// Forward select 2'b10 takes memory stage, 2'b01 takes writeback
	typedef struct packed {
		logic stallFetch;
		logic stallDecode;
		logic flushExecute;
		logic [1:0] fwdA;
		logic [1:0] fwdB;
		logic fwdDecA;
		logic fwdDecB;
	} hazard_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [11:0] adr;
		logic [DataWidth-1:0] dat;
	} wbReq_t;

	typedef struct packed {
		logic ack;
		logic [DataWidth-1:0] dat;
	} wbRsp_t;

	typedef struct packed {
		logic run;
		logic imemWe;
		logic dmemWe;
		logic [9:0] addr;
		logic [DataWidth-1:0] data;
		logic [RegAddrBits-1:0] regIdx;
	} debugBus_t;

	typedef struct packed {
		logic halted;
		logic retire;
		logic [DataWidth-1:0] imemData;
		logic [DataWidth-1:0] dmemData;
		logic [DataWidth-1:0] regData;
	} coreStatus_t;

	// Regions decoded from adr[11:10]
	localparam logic [1:0] RegionImem = 2'd0;
	localparam logic [1:0] RegionDmem = 2'd1;
	localparam logic [1:0] RegionRegs = 2'd2;
	localparam logic [1:0] RegionCtrl = 2'd3;

	// Word offsets in the control region
	localparam logic [9:0] CtrlRun     = 10'd0;
	localparam logic [9:0] CtrlStatus  = 10'd1;
	localparam logic [9:0] CtrlRetired = 10'd2;

endpackage

`default_nettype wire

// File: hw/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
	input  mipsPkg::instr_u instr,
	output mipsPkg::ctrl_t  ctrl
);

	always_comb begin
		ctrl = '0;
		case (instr.r.op)
			mipsPkg::OpRtype: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				case (instr.r.func)
					mipsPkg::FuncAdd: ctrl.aluOp = mipsPkg::AluAdd;
					mipsPkg::FuncSub: ctrl.aluOp = mipsPkg::AluSub;
					mipsPkg::FuncAnd: ctrl.aluOp = mipsPkg::AluAnd;
					mipsPkg::FuncOr:  ctrl.aluOp = mipsPkg::AluOr;
					mipsPkg::FuncSlt: ctrl.aluOp = mipsPkg::AluSlt;
					// Unknown function code retires nothing
					default: ctrl = '0;
				endcase
			end
			mipsPkg::OpAddi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsPkg::AluAdd;
			end
			mipsPkg::OpAndi: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.zeroExt = 1'b1;
				ctrl.aluOp = mipsPkg::AluAnd;
			end
			mipsPkg::OpOri: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.zeroExt = 1'b1;
				ctrl.aluOp = mipsPkg::AluOr;
			end
			mipsPkg::OpLw: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsPkg::AluAdd;
			end
			mipsPkg::OpSw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluOp = mipsPkg::AluAdd;
			end
			mipsPkg::OpBeq: ctrl.branch = 1'b1;
			mipsPkg::OpBne: begin
				ctrl.branch = 1'b1;
				ctrl.branchNe = 1'b1;
			end
			mipsPkg::OpHalt: ctrl.halt = 1'b1;
			default: ctrl = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [mipsPkg::RegAddrBits-1:0]    rs,
	input  logic [mipsPkg::RegAddrBits-1:0]    rt,
	input  logic [mipsPkg::RegAddrBits-1:0]    debugIdx,
	input  logic                               writeEn,
	input  logic [mipsPkg::RegAddrBits-1:0]    writeIdx,
	input  logic [mipsPkg::DataWidth-1:0]      writeData,
	output logic [mipsPkg::DataWidth-1:0]      rsData,
	output logic [mipsPkg::DataWidth-1:0]      rtData,
	output logic [mipsPkg::DataWidth-1:0]      debugData
);

	logic [mipsPkg::DataWidth-1:0] regs [2**mipsPkg::RegAddrBits];

	// Write-first read, so writeback is seen by decode in the same cycle
	function automatic logic [mipsPkg::DataWidth-1:0] readPort(
		input logic [mipsPkg::RegAddrBits-1:0] idx);
		if (idx == '0)
			return '0;
		if (writeEn && writeIdx == idx)
			return writeData;
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**mipsPkg::RegAddrBits; i++)
				regs[i] <= '0;
		end else if (writeEn && writeIdx != '0) begin
			regs[writeIdx] <= writeData;
		end
	end

	always_comb begin
		rsData = readPort(rs);
		rtData = readPort(rt);
		debugData = readPort(debugIdx);
	end

endmodule

`default_nettype wire

// File: hw/hazardUnit.sv
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
	input  logic [mipsPkg::RegAddrBits-1:0]    decRs,
	input  logic [mipsPkg::RegAddrBits-1:0]    decRt,
	input  mipsPkg::ctrl_t                     decCtrl,
	input  mipsPkg::idEx_t                     idEx,
	input  mipsPkg::exMem_t                    exMem,
	input  mipsPkg::memWb_t                    memWb,
	input  logic [mipsPkg::RegAddrBits-1:0]    exDest,
	output mipsPkg::hazard_t                   hazard
);

	logic loadUse;
	logic branchStall;

	// Memory stage wins over writeback, it holds the newer value
	function automatic logic [1:0] fwdSel(
		input logic [mipsPkg::RegAddrBits-1:0] src,
		input mipsPkg::exMem_t m,
		input mipsPkg::memWb_t w);
		if (src != '0 && m.ctrl.regWrite && m.dest == src)
			return 2'b10;
		if (src != '0 && w.ctrl.regWrite && w.dest == src)
			return 2'b01;
		return 2'b00;
	endfunction

	assign loadUse = idEx.ctrl.memToReg && (idEx.rt == decRs || idEx.rt == decRt);

	// Branch compares in decode need their sources one stage early
	assign branchStall = decCtrl.branch &&
		((idEx.ctrl.regWrite && exDest != '0 && (exDest == decRs || exDest == decRt)) ||
		(exMem.ctrl.memToReg && (exMem.dest == decRs || exMem.dest == decRt)));

	always_comb begin
		hazard.stallFetch = loadUse || branchStall;
		hazard.stallDecode = loadUse || branchStall;
		hazard.flushExecute = loadUse || branchStall;
		hazard.fwdA = fwdSel(idEx.rs, exMem, memWb);
		hazard.fwdB = fwdSel(idEx.rt, exMem, memWb);
		hazard.fwdDecA = decRs != '0 && exMem.ctrl.regWrite && exMem.dest == decRs;
		hazard.fwdDecB = decRt != '0 && exMem.ctrl.regWrite && exMem.dest == decRt;
	end

endmodule

`default_nettype wire

// File: hw/pipelineCore.sv
`timescale 1ns/1ps
`default_nettype none

module pipelineCore #(
	parameter int ImemAddrBits = 8,
	parameter int DmemAddrBits = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mipsPkg::debugBus_t     debug,
	output mipsPkg::coreStatus_t   status
);

	logic [mipsPkg::DataWidth-1:0] imem [2**ImemAddrBits];
	logic [mipsPkg::DataWidth-1:0] dmem [2**DmemAddrBits];

	logic [ImemAddrBits-1:0] pc, pcPlusOne, pcNext, branchTarget, idPcPlus;
	logic [mipsPkg::DataWidth-1:0] imemDbg, regDbg;
	mipsPkg::instr_u idInstr;
	logic haltFetch, haltDecode;

	mipsPkg::ctrl_t decCtrl;
	logic [mipsPkg::DataWidth-1:0] rsData, rtData, decImm, branchA, branchB;
	logic branchTaken;

	mipsPkg::idEx_t idEx;
	mipsPkg::exMem_t exMem;
	mipsPkg::memWb_t memWb;
	mipsPkg::hazard_t hazard;

	logic [mipsPkg::DataWidth-1:0] srcA, srcB, aluB, aluResult, resultWb;
	logic [mipsPkg::RegAddrBits-1:0] exDest;

	logic dmemWe;
	logic [DmemAddrBits-1:0] dmemAddr;
	logic [mipsPkg::DataWidth-1:0] dmemWdata;

	function automatic logic [mipsPkg::DataWidth-1:0] fwdMux(input logic [1:0] sel,
		input logic [mipsPkg::DataWidth-1:0] regVal, memVal, wbVal);
		case (sel)
			2'b10: return memVal;
			2'b01: return wbVal;
			default: return regVal;
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Fetch

	assign pcPlusOne = pc + 1'b1;
	assign pcNext = branchTaken ? branchTarget : pcPlusOne;
	// HALT in decode stops fetch for good, only bubbles follow it
	assign haltDecode = decCtrl.halt && !hazard.stallDecode;

	always_ff @(posedge clk) begin
		if (rst || !debug.run)
			pc <= '0;
		else if (!hazard.stallFetch && !decCtrl.halt && !haltFetch)
			pc <= pcNext;
	end

	always_ff @(posedge clk) begin
		if (rst || !debug.run)
			haltFetch <= 1'b0;
		else if (haltDecode)
			haltFetch <= 1'b1;
	end

	// Loaded only through the debug port
	always_ff @(posedge clk) begin
		if (debug.imemWe)
			imem[debug.addr[ImemAddrBits-1:0]] <= debug.data;
		imemDbg <= imem[debug.addr[ImemAddrBits-1:0]];
	end

	always_ff @(posedge clk) begin
		if (rst || !debug.run || branchTaken || haltDecode || haltFetch) begin
			idInstr <= '0;
			idPcPlus <= '0;
		end else if (!hazard.stallDecode) begin
			idInstr <= imem[pc];
			idPcPlus <= pcPlusOne;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Decode and branch resolve

	controlDecoder u_controlDecoder (
		.instr (idInstr),
		.ctrl  (decCtrl)
	);

	registerFile u_registerFile (
		.clk       (clk),
		.rst       (rst),
		.rs        (idInstr.r.rs),
		.rt        (idInstr.r.rt),
		.debugIdx  (debug.regIdx),
		.writeEn   (memWb.ctrl.regWrite),
		.writeIdx  (memWb.dest),
		.writeData (resultWb),
		.rsData    (rsData),
		.rtData    (rtData),
		.debugData (regDbg)
	);

	hazardUnit u_hazardUnit (
		.decRs   (idInstr.r.rs),
		.decRt   (idInstr.r.rt),
		.decCtrl (decCtrl),
		.idEx    (idEx),
		.exMem   (exMem),
		.memWb   (memWb),
		.exDest  (exDest),
		.hazard  (hazard)
	);

	assign decImm = decCtrl.zeroExt ? {16'b0, idInstr.i.imm16} :
		{{16{idInstr.i.imm16[15]}}, idInstr.i.imm16};
	// Word addressed, so the offset adds straight to pc+1
	assign branchTarget = idPcPlus + decImm[ImemAddrBits-1:0];
	assign branchA = hazard.fwdDecA ? exMem.aluResult : rsData;
	assign branchB = hazard.fwdDecB ? exMem.aluResult : rtData;
	assign branchTaken = decCtrl.branch && !hazard.stallDecode &&
		((branchA == branchB) != decCtrl.branchNe);

	always_ff @(posedge clk) begin
		if (rst || !debug.run || hazard.flushExecute) begin
			idEx <= '0;
		end else begin
			idEx.ctrl <= decCtrl;
			idEx.rsData <= rsData;
			idEx.rtData <= rtData;
			idEx.imm <= decImm;
			idEx.rs <= idInstr.r.rs;
			idEx.rt <= idInstr.r.rt;
			idEx.rd <= idInstr.r.rd;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Execute

	assign srcA = fwdMux(hazard.fwdA, idEx.rsData, exMem.aluResult, resultWb);
	assign srcB = fwdMux(hazard.fwdB, idEx.rtData, exMem.aluResult, resultWb);
	assign aluB = idEx.ctrl.aluSrc ? idEx.imm : srcB;
	assign exDest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

	always_comb begin
		case (idEx.ctrl.aluOp)
			mipsPkg::AluAdd: aluResult = srcA + aluB;
			mipsPkg::AluSub: aluResult = srcA - aluB;
			mipsPkg::AluAnd: aluResult = srcA & aluB;
			mipsPkg::AluOr:  aluResult = srcA | aluB;
			mipsPkg::AluSlt: aluResult = ($signed(srcA) < $signed(aluB)) ? 32'd1 : 32'd0;
			default: aluResult = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst || !debug.run) begin
			exMem <= '0;
		end else begin
			exMem.ctrl <= idEx.ctrl;
			exMem.aluResult <= aluResult;
			exMem.storeData <= srcB;
			exMem.dest <= exDest;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Memory and writeback

	// Debug owns the data memory port while stopped
	assign dmemWe = debug.run ? exMem.ctrl.memWrite : debug.dmemWe;
	assign dmemAddr = debug.run ? exMem.aluResult[DmemAddrBits-1:0] :
		debug.addr[DmemAddrBits-1:0];
	assign dmemWdata = debug.run ? exMem.storeData : debug.data;

	always_ff @(posedge clk) begin
		if (dmemWe)
			dmem[dmemAddr] <= dmemWdata;
		memWb.loadData <= dmem[dmemAddr];
		memWb.aluResult <= exMem.aluResult;
		memWb.dest <= exMem.dest;
		if (rst || !debug.run)
			memWb.ctrl <= '0;
		else
			memWb.ctrl <= exMem.ctrl;
	end

	assign resultWb = memWb.ctrl.memToReg ? memWb.loadData : memWb.aluResult;

	// Bubbles carry an all-zero control word and never count
	assign status.retire = memWb.ctrl != '0;
	assign status.halted = memWb.ctrl.halt;
	assign status.imemData = imemDbg;
	assign status.dmemData = memWb.loadData;
	assign status.regData = regDbg;

endmodule

`default_nettype wire

// File: hw/debugRegs.sv
`timescale 1ns/1ps
`default_nettype none

module debugRegs #(
	parameter int ImemAddrBits = 8,
	parameter int DmemAddrBits = 8
) (
	input  logic                   clk,
	input  logic                   rst,
	input  mipsPkg::wbReq_t        wbReq,
	output mipsPkg::wbRsp_t        wbRsp,
	output mipsPkg::debugBus_t     debug,
	input  mipsPkg::coreStatus_t   status,
	output logic                   halted
);

	logic [1:0] phase;
	logic ack, writeAck, runWrite, runQ, haltedQ, imemFits, dmemFits;
	logic [1:0] region;
	logic [9:0] offset;
	logic [mipsPkg::DataWidth-1:0] retired, readData;

	assign region = wbReq.adr[11:10];
	assign offset = wbReq.adr[9:0];
	assign imemFits = int'(offset) < (1 << ImemAddrBits);
	assign dmemFits = int'(offset) < (1 << DmemAddrBits);

	// Phase 1 gives the memories a cycle to read, ack in phase 2
	assign ack = phase == 2'd2;
	assign writeAck = ack && wbReq.we;
	assign runWrite = writeAck && region == mipsPkg::RegionCtrl && offset == mipsPkg::CtrlRun;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase <= 2'd0;
		end else begin
			case (phase)
				2'd0: if (wbReq.cyc && wbReq.stb) phase <= 2'd1;
				2'd1: phase <= 2'd2;
				default: phase <= 2'd0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			runQ <= 1'b0;
			haltedQ <= 1'b0;
			retired <= '0;
		end else if (runWrite) begin
			runQ <= wbReq.dat[0];
			if (wbReq.dat[0]) begin
				haltedQ <= 1'b0;
				retired <= '0;
			end
		end else if (runQ) begin
			if (status.retire)
				retired <= retired + 1'b1;
			if (status.halted) begin
				runQ <= 1'b0;
				haltedQ <= 1'b1;
			end
		end
	end

	always_comb begin
		debug.run = runQ;
		debug.imemWe = writeAck && !runQ && region == mipsPkg::RegionImem && imemFits;
		debug.dmemWe = writeAck && !runQ && region == mipsPkg::RegionDmem && dmemFits;
		debug.addr = offset;
		debug.data = wbReq.dat;
		debug.regIdx = wbReq.adr[mipsPkg::RegAddrBits-1:0];
	end

	// Memory windows read as zero while the core owns them
	always_comb begin
		readData = '0;
		case (region)
			mipsPkg::RegionImem: if (!runQ && imemFits) readData = status.imemData;
			mipsPkg::RegionDmem: if (!runQ && dmemFits) readData = status.dmemData;
			mipsPkg::RegionRegs: readData = status.regData;
			mipsPkg::RegionCtrl: begin
				case (offset)
					mipsPkg::CtrlRun:     readData = {31'b0, runQ};
					mipsPkg::CtrlStatus:  readData = {30'b0, runQ, haltedQ};
					mipsPkg::CtrlRetired: readData = retired;
					default: readData = '0;
				endcase
			end
			default: readData = '0;
		endcase
	end

	assign wbRsp.ack = ack;
	assign wbRsp.dat = readData;
	assign halted = haltedQ;

endmodule

`default_nettype wire

// File: hw/mipsTop.sv
`timescale 1ns/1ps
`default_nettype none

module mipsTop #(
	parameter int ImemAddrBits = 8,
	parameter int DmemAddrBits = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  mipsPkg::wbReq_t    wbReq,
	output mipsPkg::wbRsp_t    wbRsp,
	output logic               halted
);

	mipsPkg::debugBus_t debug;
	mipsPkg::coreStatus_t status;

	debugRegs #(
		.ImemAddrBits (ImemAddrBits),
		.DmemAddrBits (DmemAddrBits)
	) u_debugRegs (
		.clk    (clk),
		.rst    (rst),
		.wbReq  (wbReq),
		.wbRsp  (wbRsp),
		.debug  (debug),
		.status (status),
		.halted (halted)
	);

	pipelineCore #(
		.ImemAddrBits (ImemAddrBits),
		.DmemAddrBits (DmemAddrBits)
	) u_pipelineCore (
		.clk    (clk),
		.rst    (rst),
		.debug  (debug),
		.status (status)
	);

endmodule

`default_nettype wire

// File: verif/tbTable.svh
`ifndef TB_TABLE_SVH
`define TB_TABLE_SVH

typedef enum int {
	StepWrite,
	StepRead,
	StepWaitHalted
} stepKind_e;

typedef struct {
	string name;
	stepKind_e kind;
	logic [11:0] adr;
	logic [31:0] data;
	logic [31:0] expected;
} step_t;

step_t steps [$];
logic [31:0] programWords [$];

// MIPS opcode and function encodings
localparam logic [5:0] OpBeq  = 6'h04;
localparam logic [5:0] OpBne  = 6'h05;
localparam logic [5:0] OpAddi = 6'h08;
localparam logic [5:0] OpAndi = 6'h0c;
localparam logic [5:0] OpOri  = 6'h0d;
localparam logic [5:0] OpLw   = 6'h23;
localparam logic [5:0] OpSw   = 6'h2b;
localparam logic [5:0] OpHalt = 6'h3f;
localparam logic [5:0] FnAdd  = 6'h20;
localparam logic [5:0] FnSub  = 6'h22;
localparam logic [5:0] FnAnd  = 6'h24;
localparam logic [5:0] FnOr   = 6'h25;
localparam logic [5:0] FnSlt  = 6'h2a;

// Immediates shared by the program and the expected values
localparam logic [15:0] ImmCount    = 16'd3;
localparam logic [15:0] ImmNegOne   = 16'hffff;
localparam logic [15:0] ImmOri      = 16'h8001;
localparam logic [15:0] ImmAndi     = 16'h8f0f;
localparam logic [15:0] ImmStep     = 16'd5;
localparam logic [15:0] ImmMark     = 16'h0077;
localparam logic [15:0] StoreOffset = 16'd4;

// Loop body spans these instruction indices
localparam int LoopStart = 13;
localparam int LoopEnd   = 15;

function automatic logic [31:0] encodeI(input logic [5:0] op, input int rs, input int rt,
	input logic [15:0] imm);
	return {op, 5'(rs), 5'(rt), imm};
endfunction

function automatic logic [31:0] encodeR(input int rs, input int rt, input int rd,
	input logic [5:0] func);
	return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, func};
endfunction

function automatic logic [11:0] regionAdr(input logic [1:0] region, input int offset);
	return {region, 10'(offset)};
endfunction

task automatic addStep(input string name, input stepKind_e kind, input logic [11:0] adr,
	input logic [31:0] data, input logic [31:0] expected);
	step_t s;
	s.name = name;
	s.kind = kind;
	s.adr = adr;
	s.data = data;
	s.expected = expected;
	steps.push_back(s);
endtask

task automatic fillProgram();
	programWords.delete();
	programWords.push_back(encodeI(OpAddi, 0, 1, ImmCount));
	programWords.push_back(encodeI(OpAddi, 0, 4, ImmNegOne));
	programWords.push_back(encodeI(OpOri, 0, 2, ImmOri));
	programWords.push_back(encodeI(OpAndi, 4, 5, ImmAndi));
	// Back-to-back R-type chain
	programWords.push_back(encodeR(2, 5, 6, FnAdd));
	programWords.push_back(encodeR(6, 2, 7, FnSub));
	programWords.push_back(encodeR(7, 6, 8, FnAnd));
	programWords.push_back(encodeR(8, 2, 9, FnOr));
	programWords.push_back(encodeR(4, 9, 10, FnSlt));
	// Loads with an immediate use
	programWords.push_back(encodeI(OpLw, 0, 11, 16'd0));
	programWords.push_back(encodeI(OpLw, 0, 12, 16'd1));
	programWords.push_back(encodeR(11, 12, 13, FnAdd));
	programWords.push_back(encodeI(OpAddi, 0, 14, 16'd0));
	// Countdown loop, BNE back to LoopStart
	programWords.push_back(encodeI(OpAddi, 14, 14, ImmStep));
	programWords.push_back(encodeI(OpAddi, 1, 1, ImmNegOne));
	programWords.push_back(encodeI(OpBne, 1, 0, 16'(LoopStart - LoopEnd - 1)));
	// Not taken, would skip to HALT
	programWords.push_back(encodeI(OpBeq, 14, 0, 16'd3));
	programWords.push_back(encodeI(OpAddi, 0, 15, ImmMark));
	// Write to r0 is dropped, the store base stays zero
	programWords.push_back(encodeI(OpAddi, 0, 0, ImmMark));
	programWords.push_back(encodeI(OpSw, 0, 13, StoreOffset));
	programWords.push_back({OpHalt, 26'd0});
endtask

`endif

// File: verif/mipsTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsTb;

	localparam int ClkHalf = 20;
	localparam int ResetCycles = 16;
	localparam int DriveDelay = 2;
	localparam int SampleDelay = 1;
	localparam int CyclesPerStep = 10;
	localparam int ProgramCycles = 400;
	localparam logic [31:0] Seed = 32'h9eff_f7d3;

	logic clk;
	logic rst;
	mipsPkg::wbReq_t wbReq;
	mipsPkg::wbRsp_t wbRsp;
	logic halted;

	`include "tbTable.svh"

	logic [31:0] randA;
	logic [31:0] randB;
	logic [31:0] expRegs [16];
	int expRetired;
	int cycleCount;
	int cycleLimit;

	mipsTop u_mipsTop (
		.clk    (clk),
		.rst    (rst),
		.wbReq  (wbReq),
		.wbRsp  (wbRsp),
		.halted (halted)
	);

	always #ClkHalf clk = ~clk;

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("TIMEOUT: run did not finish within %0d cycles", cycleLimit);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks and bus access

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s: expected %08h, actual %08h", name, expected, actual);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic wbTransfer(input logic write, input logic [11:0] adr,
		input logic [31:0] data, output logic [31:0] readData);
		@(posedge clk);
		#DriveDelay;
		wbReq.cyc = 1'b1;
		wbReq.stb = 1'b1;
		wbReq.we = write;
		wbReq.adr = adr;
		wbReq.dat = data;
		do begin
			@(posedge clk);
			#SampleDelay;
		end while (!wbRsp.ack);
		readData = wbRsp.dat;
		// Hold through the ack edge, drop in the next cycle
		@(posedge clk);
		#DriveDelay;
		wbReq = '0;
	endtask

	// Start must have cleared halted before the program runs
	task automatic waitHalted(input string name);
		checkValue({name, " halted low at start"}, 32'd0, {31'b0, halted});
		do begin
			@(posedge clk);
			#SampleDelay;
		end while (!halted);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Expected results from instruction semantics

	task automatic computeExpected();
		logic [31:0] counter;
		logic [31:0] acc;
		int loopPasses;
		logic beqTaken;
		foreach (expRegs[r])
			expRegs[r] = '0;
		expRegs[2] = {16'h0000, ImmOri};
		expRegs[4] = {{16{ImmNegOne[15]}}, ImmNegOne};
		expRegs[5] = expRegs[4] & {16'h0000, ImmAndi};
		expRegs[6] = expRegs[2] + expRegs[5];
		expRegs[7] = expRegs[6] - expRegs[2];
		expRegs[8] = expRegs[7] & expRegs[6];
		expRegs[9] = expRegs[8] | expRegs[2];
		expRegs[10] = ($signed(expRegs[4]) < $signed(expRegs[9])) ? 32'd1 : 32'd0;
		expRegs[11] = randA;
		expRegs[12] = randB;
		expRegs[13] = randA + randB;
		counter = {16'h0000, ImmCount};
		acc = '0;
		loopPasses = 0;
		do begin
			acc = acc + {16'h0000, ImmStep};
			counter = counter - 32'd1;
			loopPasses++;
		end while (counter != '0);
		expRegs[1] = counter;
		expRegs[14] = acc;
		beqTaken = acc == '0;
		expRegs[15] = beqTaken ? 32'd0 : {16'h0000, ImmMark};
		// Taken BEQ jumps straight to HALT
		expRetired = LoopStart + loopPasses * (LoopEnd - LoopStart + 1) +
			(beqTaken ? 2 : programWords.size() - LoopEnd - 1);
	endtask

	task automatic buildTable();
		logic [11:0] statusAdr;
		logic [11:0] retiredAdr;
		logic [11:0] runAdr;
		statusAdr = regionAdr(mipsPkg::RegionCtrl, int'(mipsPkg::CtrlStatus));
		retiredAdr = regionAdr(mipsPkg::RegionCtrl, int'(mipsPkg::CtrlRetired));
		runAdr = regionAdr(mipsPkg::RegionCtrl, int'(mipsPkg::CtrlRun));
		addStep("reset status", StepRead, statusAdr, '0, 32'd0);
		addStep("reset retired", StepRead, retiredAdr, '0, 32'd0);
		addStep("dmem 0 write", StepWrite, regionAdr(mipsPkg::RegionDmem, 0), randA, '0);
		addStep("dmem 1 write", StepWrite, regionAdr(mipsPkg::RegionDmem, 1), randB, '0);
		addStep("dmem 0 readback", StepRead, regionAdr(mipsPkg::RegionDmem, 0), '0, randA);
		addStep("dmem 1 readback", StepRead, regionAdr(mipsPkg::RegionDmem, 1), '0, randB);
		addStep("stopped reg 0", StepRead, regionAdr(mipsPkg::RegionRegs, 0), '0, 32'd0);
		addStep("stopped reg 13", StepRead, regionAdr(mipsPkg::RegionRegs, 13), '0, 32'd0);
		foreach (programWords[i])
			addStep($sformatf("imem %0d", i), StepWrite, regionAdr(mipsPkg::RegionImem, i),
				programWords[i], '0);
		// Second pass checks the restart from PC 0
		for (int pass = 1; pass <= 2; pass++) begin
			addStep($sformatf("dmem store clear %0d", pass), StepWrite,
				regionAdr(mipsPkg::RegionDmem, int'(StoreOffset)), 32'd0, '0);
			addStep($sformatf("start %0d", pass), StepWrite, runAdr, 32'd1, '0);
			addStep($sformatf("halt %0d", pass), StepWaitHalted, '0, '0, '0);
			for (int r = 0; r < 16; r++)
				addStep($sformatf("run %0d reg %0d", pass, r), StepRead,
					regionAdr(mipsPkg::RegionRegs, r), '0, expRegs[r]);
			addStep($sformatf("run %0d status", pass), StepRead, statusAdr, '0, 32'd1);
			addStep($sformatf("run %0d retired", pass), StepRead, retiredAdr, '0,
				32'(expRetired));
			addStep($sformatf("run %0d stored word", pass), StepRead,
				regionAdr(mipsPkg::RegionDmem, int'(StoreOffset)), '0, expRegs[13]);
		end
	endtask

	task automatic runTable();
		logic [31:0] readData;
		foreach (steps[i]) begin
			case (steps[i].kind)
				StepWrite: wbTransfer(1'b1, steps[i].adr, steps[i].data, readData);
				StepRead: begin
					wbTransfer(1'b0, steps[i].adr, '0, readData);
					checkValue(steps[i].name, steps[i].expected, readData);
				end
				default: waitHalted(steps[i].name);
			endcase
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		wbReq = '0;
		cycleCount = 0;
		cycleLimit = 0;
		void'($urandom(Seed));
		randA = $urandom();
		randB = $urandom();
		fillProgram();
		computeExpected();
		buildTable();
		cycleLimit = steps.size() * CyclesPerStep + ProgramCycles;
		repeat (ResetCycles) @(posedge clk);
		#DriveDelay;
		rst = 1'b0;
		runTable();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+verif
hw/mipsPkg.sv
hw/controlDecoder.sv
hw/registerFile.sv
hw/hazardUnit.sv
hw/pipelineCore.sv
hw/debugRegs.sv
hw/mipsTop.sv
verif/mipsTb.sv

// File: Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = mipsTb
FILELIST   = build.f
OBJ_DIR    = obj_dir
PASS_MSG   = ALL CHECKS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
